//--- tb.f
design/ntps_pkg.sv
design/ntps_bus_ctrl.sv
design/ntps_path_regs.sv
design/ntps_clock_select.sv
design/ntps_interfaces.sv
+incdir+sim
sim/tb_ntps_interfaces.sv

//--- Bender.yml
package:
  name: ntps_interfaces

sources:
  - files:
      - design/ntps_pkg.sv
      - design/ntps_bus_ctrl.sv
      - design/ntps_path_regs.sv
      - design/ntps_clock_select.sv
      - design/ntps_interfaces.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_ntps_interfaces.sv

//--- sim/tb_ntps_tasks.svh
/*
 * Bus tasks, compare tasks and directed tests for the register testbench.
 * Included inside the testbench module and uses its signals directly.
 */

// ----------------------------------------
// Helpers
// ----------------------------------------
function automatic word_t xorshift32(input word_t x);
  word_t y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic word_t next_rand();
  rng_state = xorshift32(rng_state);
  return rng_state;
endfunction

// Slot in the upper bits, index in the lower
function automatic wb_addr_t make_addr(input int slot, input reg_idx_t idx);
  return {slot_t'(slot), idx};
endfunction

task automatic check_word(input string name, input word_t exp, input word_t act);
  if (act !== exp) begin
    mismatch_count++;
    $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
  end
endtask

task automatic check_time(input string name, input ntp_time_t exp, input ntp_time_t act);
  if (act !== exp) begin
    mismatch_count++;
    $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    mismatch_count++;
    $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
  end
endtask

// ----------------------------------------
// Wishbone classic master
// ----------------------------------------
// Signals sampled at the edge hold their values from the cycle before
task automatic bus_access(input logic we, input wb_addr_t adr, input word_t wdata,
                          output word_t rdata);
  int waited;
  @(posedge clk156);
  wb_cyc   <= 1'b1;
  wb_stb   <= 1'b1;
  wb_we    <= we;
  wb_adr   <= adr;
  wb_wdata <= wdata;
  waited = 0;
  do begin
    @(posedge clk156);
    waited++;
  end while (!wb_ack && waited < ACK_LIMIT);
  if (!wb_ack) begin
    fail_count++;
    $display("No ack within %0d cycles for access to address %h", ACK_LIMIT, adr);
  end
  rdata = wb_rdata;
  // Request dropped in the cycle after ack
  wb_cyc <= 1'b0;
  wb_stb <= 1'b0;
  wb_we  <= 1'b0;
endtask

task automatic wb_write(input int slot, input reg_idx_t idx, input word_t data);
  word_t unused;
  bus_access(1'b1, make_addr(slot, idx), data, unused);
endtask

task automatic wb_read(input int slot, input reg_idx_t idx, output word_t data);
  bus_access(1'b0, make_addr(slot, idx), '0, data);
endtask

task automatic read_expect(input int slot, input reg_idx_t idx, input word_t exp);
  word_t data;
  wb_read(slot, idx, data);
  check_word($sformatf("wb_rdata (slot %0d, index %0d)", slot, idx), exp, data);
endtask

// Strobe, drop, then one cycle of selector latency
task automatic pulse_time(input logic src_b, input ntp_time_t t);
  @(posedge clk156);
  if (src_b) begin
    ntp_time_b     <= t;
    ntp_time_upd_b <= 1'b1;
  end else begin
    ntp_time_a     <= t;
    ntp_time_upd_a <= 1'b1;
  end
  @(posedge clk156);
  ntp_time_upd_a <= 1'b0;
  ntp_time_upd_b <= 1'b0;
  @(posedge clk156);
endtask

task automatic drive_sync(input logic sync_a, input logic sync_b);
  @(posedge clk156);
  ntp_sync_ok_a <= sync_a;
  ntp_sync_ok_b <= sync_b;
  repeat (2) @(posedge clk156);
endtask

// ----------------------------------------
// Directed tests
// ----------------------------------------
task automatic reset_defaults();
  check_bit("wb_ack", 1'b0, wb_ack);
  check_word("wb_rdata", '0, wb_rdata);
  check_time("ntp_time", '0, ntp_time);
  check_bit("ntp_sync_ok", 1'b0, ntp_sync_ok);
  for (int p = 0; p < NUM_PORTS; p++) begin
    read_expect(p, REG_GEN_CONFIG, '0);
  end
endtask

task automatic config_write_read();
  for (int p = 0; p < NUM_PORTS; p++) begin
    cfg_shadow[p] = next_rand();
  end
  // Keep source A selected for now
  cfg_shadow[0][24] = 1'b0;
  for (int p = 0; p < NUM_PORTS; p++) begin
    wb_write(p, REG_GEN_CONFIG, cfg_shadow[p]);
  end
  for (int p = 0; p < NUM_PORTS; p++) begin
    read_expect(p, REG_GEN_CONFIG, cfg_shadow[p]);
  end

  // Reverse order so a write leaking into a higher port shows up too
  for (int p = 0; p < NUM_PORTS; p++) begin
    cfg_shadow[p] = next_rand();
  end
  cfg_shadow[0][24] = 1'b0;
  for (int p = NUM_PORTS - 1; p >= 0; p--) begin
    wb_write(p, REG_GEN_CONFIG, cfg_shadow[p]);
  end
  for (int p = 0; p < NUM_PORTS; p++) begin
    read_expect(p, REG_GEN_CONFIG, cfg_shadow[p]);
  end
endtask

task automatic identity_and_status();
  xphy_status_t phy [NUM_PORTS];
  phy[0] = 5'h11;
  phy[1] = 5'h0a;
  phy[2] = 5'h1f;
  phy[3] = 5'h05;
  @(posedge clk156);
  xphy_status_0 <= phy[0];
  xphy_status_1 <= phy[1];
  xphy_status_2 <= phy[2];
  xphy_status_3 <= phy[3];
  for (int p = 0; p < NUM_PORTS; p++) begin
    read_expect(p, 3'd0, "ntps");
    read_expect(p, 3'd1, "path");
    read_expect(p, 3'd2, "0.10");
    read_expect(p, 3'd4, {27'd0, phy[p]});
  end
  // Read-only words of port 2 must ignore writes
  wb_write(2, 3'd0, next_rand());
  wb_write(2, 3'd1, next_rand());
  wb_write(2, 3'd2, next_rand());
  wb_write(2, 3'd4, next_rand());
  wb_write(2, 3'd5, next_rand());
  read_expect(2, 3'd0, "ntps");
  read_expect(2, 3'd1, "path");
  read_expect(2, 3'd2, "0.10");
  read_expect(2, 3'd4, {27'd0, phy[2]});
  read_expect(2, 3'd5, 32'd0);
  read_expect(2, 3'd3, cfg_shadow[2]);
endtask

task automatic unmapped_space();
  for (int s = 4; s < 8; s++) begin
    read_expect(s, 3'd0, '0);
    read_expect(s, 3'd3, '0);
  end
  for (int p = 0; p < NUM_PORTS; p++) begin
    read_expect(p, 3'd6, '0);
    read_expect(p, 3'd7, '0);
  end
  wb_write(5, 3'd3, next_rand());
  for (int p = 0; p < NUM_PORTS; p++) begin
    read_expect(p, 3'd3, cfg_shadow[p]);
  end
endtask

task automatic clock_selection();
  ntp_time_t t_a;
  ntp_time_t t_b;
  t_a = {next_rand(), next_rand()};
  t_b = {next_rand(), next_rand()};

  // Source A selected
  pulse_time(1'b0, t_a);
  check_time("ntp_time", t_a, ntp_time);
  pulse_time(1'b1, t_b);
  check_time("ntp_time", t_a, ntp_time);
  drive_sync(1'b1, 1'b0);
  check_bit("ntp_sync_ok", 1'b1, ntp_sync_ok);

  // Switch to source B through port 0 config bit 24
  cfg_shadow[0][24] = 1'b1;
  wb_write(0, 3'd3, cfg_shadow[0]);
  @(posedge clk156);
  check_bit("ntp_sync_ok", 1'b0, ntp_sync_ok);
  t_b = {next_rand(), next_rand()};
  pulse_time(1'b1, t_b);
  check_time("ntp_time", t_b, ntp_time);
  pulse_time(1'b0, {next_rand(), next_rand()});
  check_time("ntp_time", t_b, ntp_time);

  drive_sync(1'b0, 1'b1);
  check_bit("ntp_sync_ok", 1'b1, ntp_sync_ok);
  for (int p = 0; p < NUM_PORTS; p++) begin
    read_expect(p, 3'd5, 32'd1);
  end
endtask

//--- sim/tb_ntps_interfaces.sv
/*
 * Testbench top for the time-server register interface.
 * Clock, reset, DUT and watchdog live here; the bus tasks and the
 * directed tests come from the included task file.
 */

`timescale 1ns/1ps

module tb_ntps_interfaces import ntps_pkg::*; ();

  // Run limit well above the few hundred cycles the tests need
  localparam int CYCLE_LIMIT = 5000;
  // Bound on the wait for a single ack
  localparam int ACK_LIMIT   = 16;

  logic         clk156;
  logic         arst_n;
  logic         wb_cyc;
  logic         wb_stb;
  logic         wb_we;
  wb_addr_t     wb_adr;
  word_t        wb_wdata;
  word_t        wb_rdata;
  logic         wb_ack;
  xphy_status_t xphy_status_0;
  xphy_status_t xphy_status_1;
  xphy_status_t xphy_status_2;
  xphy_status_t xphy_status_3;
  ntp_time_t    ntp_time_a;
  logic         ntp_time_upd_a;
  logic         ntp_sync_ok_a;
  ntp_time_t    ntp_time_b;
  logic         ntp_time_upd_b;
  logic         ntp_sync_ok_b;
  ntp_time_t    ntp_time;
  logic         ntp_sync_ok;

  int           mismatch_count = 0;
  int           fail_count     = 0;
  int           cycle_count    = 0;
  word_t        rng_state;
  // Last value written to each port's config word
  word_t        cfg_shadow [NUM_PORTS];

  ntps_interfaces UUT (
    .clk156         (clk156),
    .arst_n         (arst_n),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_wdata       (wb_wdata),
    .wb_rdata       (wb_rdata),
    .wb_ack         (wb_ack),
    .xphy_status_0  (xphy_status_0),
    .xphy_status_1  (xphy_status_1),
    .xphy_status_2  (xphy_status_2),
    .xphy_status_3  (xphy_status_3),
    .ntp_time_a     (ntp_time_a),
    .ntp_time_upd_a (ntp_time_upd_a),
    .ntp_sync_ok_a  (ntp_sync_ok_a),
    .ntp_time_b     (ntp_time_b),
    .ntp_time_upd_b (ntp_time_upd_b),
    .ntp_sync_ok_b  (ntp_sync_ok_b),
    .ntp_time       (ntp_time),
    .ntp_sync_ok    (ntp_sync_ok)
  );

  `include "tb_ntps_tasks.svh"

  // 10 ns clock
  always #5 clk156 = ~clk156;

  // ----------------------------------------
  // Watchdog
  // ----------------------------------------
  always @(posedge clk156) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
      $display("Verification failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    clk156         = 1'b0;
    arst_n         = 1'b0;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_adr         = '0;
    wb_wdata       = '0;
    xphy_status_0  = '0;
    xphy_status_1  = '0;
    xphy_status_2  = '0;
    xphy_status_3  = '0;
    ntp_time_a     = '0;
    ntp_time_upd_a = 1'b0;
    ntp_sync_ok_a  = 1'b0;
    ntp_time_b     = '0;
    ntp_time_upd_b = 1'b0;
    ntp_sync_ok_b  = 1'b0;
    rng_state      = 32'hf75a504d;

    // Reset held for 4 cycles
    repeat (4) @(posedge clk156);
    arst_n <= 1'b1;
    @(posedge clk156);

    reset_defaults();
    config_write_read();
    identity_and_status();
    unmapped_space();
    clock_selection();

    @(posedge clk156);
    $display("Checks done: %0d mismatches, %0d other errors", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- design/ntps_interfaces.sv
/*
 * Top level of the time-server register interface.
 * A Wishbone slave reaches four network-path register blocks.
 * Port 0's config word also drives the NTP clock source select,
 * whose sync flag is reported back through every path block.
 */

`timescale 1ns/1ps

module ntps_interfaces import ntps_pkg::*; (
  input  logic         clk156,
  input  logic         arst_n,

  // Wishbone classic slave
  input  logic         wb_cyc,
  input  logic         wb_stb,
  input  logic         wb_we,
  input  wb_addr_t     wb_adr,
  input  word_t        wb_wdata,
  output word_t        wb_rdata,
  output logic         wb_ack,

  // PHY status per port
  input  xphy_status_t xphy_status_0,
  input  xphy_status_t xphy_status_1,
  input  xphy_status_t xphy_status_2,
  input  xphy_status_t xphy_status_3,

  // NTP sources
  input  ntp_time_t    ntp_time_a,
  input  logic         ntp_time_upd_a,
  input  logic         ntp_sync_ok_a,
  input  ntp_time_t    ntp_time_b,
  input  logic         ntp_time_upd_b,
  input  logic         ntp_sync_ok_b,

  // Selected time out
  output ntp_time_t    ntp_time,
  output logic         ntp_sync_ok
);

  logic     path_we [NUM_PORTS];
  word_t    path_rdata [NUM_PORTS];
  reg_idx_t reg_idx;
  word_t    reg_wdata;
  word_t    gen_config_0;

  // ----------------------------------------
  // Bus front end
  // ----------------------------------------
  ntps_bus_ctrl bus_ctrl (
    .clk156       (clk156),
    .arst_n       (arst_n),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_wdata     (wb_wdata),
    .wb_ack       (wb_ack),
    .wb_rdata     (wb_rdata),
    .path_we_0    (path_we[0]),
    .path_we_1    (path_we[1]),
    .path_we_2    (path_we[2]),
    .path_we_3    (path_we[3]),
    .reg_idx      (reg_idx),
    .reg_wdata    (reg_wdata),
    .path_rdata_0 (path_rdata[0]),
    .path_rdata_1 (path_rdata[1]),
    .path_rdata_2 (path_rdata[2]),
    .path_rdata_3 (path_rdata[3])
  );

  // ----------------------------------------
  // Network path register blocks
  // ----------------------------------------
  // Config of ports 1..3 has no consumer without the PHYs
  ntps_path_regs path_regs_0 (
    .clk156 (clk156), .arst_n (arst_n),
    .we (path_we[0]), .reg_idx (reg_idx), .wdata (reg_wdata), .rdata (path_rdata[0]),
    .xphy_status (xphy_status_0), .ntp_sync_ok (ntp_sync_ok), .gen_config (gen_config_0)
  );

  ntps_path_regs path_regs_1 (
    .clk156 (clk156), .arst_n (arst_n),
    .we (path_we[1]), .reg_idx (reg_idx), .wdata (reg_wdata), .rdata (path_rdata[1]),
    .xphy_status (xphy_status_1), .ntp_sync_ok (ntp_sync_ok), .gen_config ()
  );

  ntps_path_regs path_regs_2 (
    .clk156 (clk156), .arst_n (arst_n),
    .we (path_we[2]), .reg_idx (reg_idx), .wdata (reg_wdata), .rdata (path_rdata[2]),
    .xphy_status (xphy_status_2), .ntp_sync_ok (ntp_sync_ok), .gen_config ()
  );

  ntps_path_regs path_regs_3 (
    .clk156 (clk156), .arst_n (arst_n),
    .we (path_we[3]), .reg_idx (reg_idx), .wdata (reg_wdata), .rdata (path_rdata[3]),
    .xphy_status (xphy_status_3), .ntp_sync_ok (ntp_sync_ok), .gen_config ()
  );

  // ----------------------------------------
  // NTP source select from port 0 config
  // ----------------------------------------
  ntps_clock_select clock_select (
    .clk156         (clk156),
    .arst_n         (arst_n),
    .select         (gen_config_0[CLK_SELECT_BIT]),
    .ntp_time_a     (ntp_time_a),
    .ntp_time_upd_a (ntp_time_upd_a),
    .ntp_sync_ok_a  (ntp_sync_ok_a),
    .ntp_time_b     (ntp_time_b),
    .ntp_time_upd_b (ntp_time_upd_b),
    .ntp_sync_ok_b  (ntp_sync_ok_b),
    .ntp_time       (ntp_time),
    .ntp_sync_ok    (ntp_sync_ok)
  );

endmodule

//--- design/ntps_clock_select.sv
/*
 * Picks one of two NTP time sources and holds its time and sync flag.
 * Select low takes source A, select high takes source B.
 * Time loads one cycle after the chosen source's update strobe.
 */

`timescale 1ns/1ps

module ntps_clock_select import ntps_pkg::*; (
  input  logic      clk156,
  input  logic      arst_n,

  input  logic      select,

  // Source A
  input  ntp_time_t ntp_time_a,
  input  logic      ntp_time_upd_a,
  input  logic      ntp_sync_ok_a,

  // Source B
  input  ntp_time_t ntp_time_b,
  input  logic      ntp_time_upd_b,
  input  logic      ntp_sync_ok_b,

  // Selected time
  output ntp_time_t ntp_time,
  output logic      ntp_sync_ok
);

  // ----------------------------------------
  // Time and sync hold registers
  // ----------------------------------------
  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      ntp_time    <= '0;
      ntp_sync_ok <= 1'b0;
    end else begin
      // Updates of the other source are ignored
      if (select && ntp_time_upd_b) begin
        ntp_time <= ntp_time_b;
      end else if (!select && ntp_time_upd_a) begin
        ntp_time <= ntp_time_a;
      end

      ntp_sync_ok <= select ? ntp_sync_ok_b : ntp_sync_ok_a;
    end
  end

endmodule

//--- design/ntps_path_regs.sv
/*
 * Register block of one network path.
 * Holds the writable general config word and answers reads of the
 * identity words, PHY status and the common sync flag.
 * Read data is combinational on the shared register index.
 */

`timescale 1ns/1ps

module ntps_path_regs import ntps_pkg::*; (
  input  logic         clk156,
  input  logic         arst_n,

  // Shared bus side
  input  logic         we,
  input  reg_idx_t     reg_idx,
  input  word_t        wdata,
  output word_t        rdata,

  // Status in
  input  xphy_status_t xphy_status,
  input  logic         ntp_sync_ok,

  // Config out
  output word_t        gen_config
);

  word_t gen_config_reg;
  word_t xphy_status_ext;
  word_t sync_status;

  // ----------------------------------------
  // General config register
  // ----------------------------------------
  // Only REG_GEN_CONFIG is writable
  // Writes to the other indexes are dropped
  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      gen_config_reg <= '0;
    end else if (we && (reg_idx == REG_GEN_CONFIG)) begin
      gen_config_reg <= wdata;
    end
  end

  assign gen_config = gen_config_reg;

  // ----------------------------------------
  // Read mux
  // ----------------------------------------
  // PHY status zero-extended to a full word
  assign xphy_status_ext = {{(WORD_W-XPHY_STATUS_W){1'b0}}, xphy_status};

  // Sync flag in bit 0
  assign sync_status = {{(WORD_W-1){1'b0}}, ntp_sync_ok};

  always_comb begin
    case (reg_idx)
      REG_NAME0:       rdata = PATH_NAME0;
      REG_NAME1:       rdata = PATH_NAME1;
      REG_VERSION:     rdata = PATH_VERSION;
      REG_GEN_CONFIG:  rdata = gen_config_reg;
      REG_XPHY_STATUS: rdata = xphy_status_ext;
      REG_SYNC_STATUS: rdata = sync_status;
      // Indexes 6 and 7
      default:         rdata = '0;
    endcase
  end

endmodule

//--- design/ntps_bus_ctrl.sv
/*
 * Wishbone classic slave front end for the network-path register blocks.
 * Splits the word address into slot and register index, pulses the
 * write strobe of the addressed port and registers the read data.
 * Every access is answered with a single-cycle ack, unmapped ones too.
 */

`timescale 1ns/1ps

module ntps_bus_ctrl import ntps_pkg::*; (
  input  logic     clk156,
  input  logic     arst_n,

  // Wishbone classic slave
  input  logic     wb_cyc,
  input  logic     wb_stb,
  input  logic     wb_we,
  input  wb_addr_t wb_adr,
  input  word_t    wb_wdata,
  output logic     wb_ack,
  output word_t    wb_rdata,

  // Register block side
  output logic     path_we_0,
  output logic     path_we_1,
  output logic     path_we_2,
  output logic     path_we_3,
  output reg_idx_t reg_idx,
  output word_t    reg_wdata,
  input  word_t    path_rdata_0,
  input  word_t    path_rdata_1,
  input  word_t    path_rdata_2,
  input  word_t    path_rdata_3
);

  bus_state_t           state;
  slot_t                slot;
  logic                 req;
  logic [NUM_PORTS-1:0] we_vec;
  word_t                path_rdata [NUM_PORTS];
  word_t                rdata_sel;

  // ----------------------------------------
  // Address split and request detect
  // ----------------------------------------
  assign slot      = wb_adr[ADDR_W-1:IDX_W];
  assign reg_idx   = wb_adr[IDX_W-1:0];
  assign reg_wdata = wb_wdata;

  // Taken only while idle
  // Stb is ignored in the ack cycle
  assign req = wb_cyc && wb_stb && (state == BUS_IDLE);

  assign path_rdata[0] = path_rdata_0;
  assign path_rdata[1] = path_rdata_1;
  assign path_rdata[2] = path_rdata_2;
  assign path_rdata[3] = path_rdata_3;

  // One strobe per mapped slot in the accept cycle
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      we_vec[i] = req && wb_we && (slot == slot_t'(i));
    end
  end

  assign path_we_0 = we_vec[0];
  assign path_we_1 = we_vec[1];
  assign path_we_2 = we_vec[2];
  assign path_we_3 = we_vec[3];

  // Read mux by slot
  // Slots 4..7 fall through to zero
  always_comb begin
    rdata_sel = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (slot == slot_t'(i)) begin
        rdata_sel = path_rdata[i];
      end
    end
  end

  // ----------------------------------------
  // Ack FSM and read data register
  // ----------------------------------------
  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      state    <= BUS_IDLE;
      wb_rdata <= '0;
    end else begin
      case (state)
        BUS_IDLE: begin
          if (req) begin
            state <= BUS_ACK;
            // Writes return zero on the data lines
            wb_rdata <= wb_we ? '0 : rdata_sel;
          end
        end
        BUS_ACK: begin
          state <= BUS_IDLE;
        end
        default: begin
          state <= BUS_IDLE;
        end
      endcase
    end
  end

  // One-cycle ack decoded from the state
  assign wb_ack = (state == BUS_ACK);

endmodule

//--- design/ntps_pkg.sv
/*
 * Shared definitions for the time-server interface register block.
 * Widths, the Wishbone address map, register indexes and identity words.
 * Imported by every design module through a wildcard import.
 */

package ntps_pkg;

  // ----------------------------------------
  // Widths and sizes
  // ----------------------------------------
  localparam int NUM_PORTS     = 4;
  localparam int WORD_W        = 32;
  localparam int ADDR_W        = 6;
  localparam int SLOT_W        = 3;
  localparam int IDX_W         = 3;
  localparam int XPHY_STATUS_W = 5;
  localparam int NTP_TIME_W    = 64;

  typedef logic [WORD_W-1:0]        word_t;
  typedef logic [ADDR_W-1:0]        wb_addr_t;
  typedef logic [SLOT_W-1:0]        slot_t;
  typedef logic [IDX_W-1:0]         reg_idx_t;
  typedef logic [XPHY_STATUS_W-1:0] xphy_status_t;
  typedef logic [NTP_TIME_W-1:0]    ntp_time_t;

  // ----------------------------------------
  // Register map within one slot
  // ----------------------------------------
  // Indexes 6 and 7 are unused and read as zero
  localparam reg_idx_t REG_NAME0       = 3'd0;
  localparam reg_idx_t REG_NAME1       = 3'd1;
  localparam reg_idx_t REG_VERSION     = 3'd2;
  localparam reg_idx_t REG_GEN_CONFIG  = 3'd3;
  localparam reg_idx_t REG_XPHY_STATUS = 3'd4;
  localparam reg_idx_t REG_SYNC_STATUS = 3'd5;

  // ASCII "ntps", "path", "0.10"
  localparam word_t PATH_NAME0   = 32'h6e747073;
  localparam word_t PATH_NAME1   = 32'h70617468;
  localparam word_t PATH_VERSION = 32'h302e3130;

  // Port 0 config bit choosing NTP source B
  localparam int CLK_SELECT_BIT = 24;

  // Bus controller FSM
  typedef enum logic [0:0] {
    BUS_IDLE = 1'b0,
    BUS_ACK  = 1'b1
  } bus_state_t;

endpackage
